// File: arrayPkg.sv
/*
  Array memory engine shared types
  Opcodes, response error codes, the data word and parameter defaults
*/
`default_nettype none

package arrayPkg;

  // ----------------------------------------------------------
  // Parameter defaults
  // ----------------------------------------------------------
  localparam int DefaultArrayBits = 2;          // Four arrays
  localparam int DefaultIndexBits = 2;          // Four words per array

  typedef logic [15:0] dataWord_t;              // Element and response data

  typedef enum logic [3:0] {
    opClear = 4'd0,                             // Free every array
    opAlloc = 4'd1,                             // Grant an array
    opFree  = 4'd2,                             // Return an array to the pool
    opWrite = 4'd3,
    opRead  = 4'd4,
    opSize  = 4'd5,
    opPush  = 4'd6,
    opPop   = 4'd7,
    opAdd   = 4'd8,                             // Element ops return the new value
    opAnd   = 4'd9,
    opOr    = 4'd10,
    opXor   = 4'd11
  } arrayOp_e;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                     // Array not currently granted
    errOutOfBounds  = 3'd2,                     // Index at or above size
    errFull         = 3'd3,
    errEmpty        = 3'd4,
    errOutOfMemory  = 3'd5                      // No freed and no unused array
  } arrayError_e;

endpackage

`default_nettype wire

// File: arrayIf.sv
/*
  Array memory engine internal buses
  allocIf links control to the allocator, storeIf links it to the array store
*/
`timescale 1ns/1ps
`default_nettype none

interface allocIf #(
  parameter int ArrayBits = arrayPkg::DefaultArrayBits
) ();

  logic                 clear;                  // Strobes, one cycle each
  logic                 alloc;
  logic                 free;
  logic [ArrayBits-1:0] queryArray;             // Array to test or free
  logic                 allocated;              // Allocation bit of queryArray
  logic [ArrayBits-1:0] newArray;               // Grant for the next alloc
  logic                 exhausted;              // Nothing left to grant

  modport control (output clear, alloc, free, queryArray,
                   input  allocated, newArray, exhausted);
  modport allocator (input  clear, alloc, free, queryArray,
                     output allocated, newArray, exhausted);

endinterface

interface storeIf #(
  parameter int ArrayBits = arrayPkg::DefaultArrayBits,
  parameter int IndexBits = arrayPkg::DefaultIndexBits
) ();
  import arrayPkg::*;

  arrayOp_e             op;
  logic [ArrayBits-1:0] array;
  logic [IndexBits-1:0] index;
  dataWord_t            data;
  logic                 commit;                 // State changes only on this cycle
  logic [IndexBits:0]   size;                   // Size of the addressed array
  dataWord_t            element;                // Word at array and index
  dataWord_t            result;                 // Value the op returns

  modport control (output op, array, index, data, commit,
                   input  size, element, result);
  modport store (input  op, array, index, data, commit,
                 output size, element, result);

endinterface

`default_nettype wire

// File: arrayAllocator.sv
/*
  Array allocator
  Tracks which arrays are granted, a LIFO of freed arrays and the count
  of arrays handed out at least once since the last clear
*/
`timescale 1ns/1ps
`default_nettype none

module arrayAllocator #(
  parameter int ArrayBits = arrayPkg::DefaultArrayBits
) (
  input  wire            clock,
  input  wire            resetN,
  allocIf.allocator      allocBus
);

  localparam int ArrayCount = 2 ** ArrayBits;

  logic [ArrayCount-1:0] allocBits;             // One bit per array
  logic [ArrayBits-1:0]  freedStack [ArrayCount];
  logic [ArrayBits:0]    stackTop;              // Entries on the freed stack
  logic [ArrayBits:0]    usedCount;             // Never-used arrays start here
  logic [ArrayBits-1:0]  topIndex;

  assign topIndex = ArrayBits'(stackTop - 1'b1);

  // ----------------------------------------------------------
  // Status towards control
  // ----------------------------------------------------------
  assign allocBus.allocated = allocBits[allocBus.queryArray];
  assign allocBus.newArray  = (stackTop != '0) ? freedStack[topIndex]
                                              : ArrayBits'(usedCount);
  assign allocBus.exhausted = (stackTop == '0) && (usedCount == ArrayCount);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocBits <= '0;
      stackTop  <= '0;
      usedCount <= '0;
    end else if (allocBus.clear) begin
      allocBits <= '0;                          // Drop every grant
      stackTop  <= '0;
      usedCount <= '0;
    end else if (allocBus.alloc) begin
      allocBits[allocBus.newArray] <= 1'b1;
      if (stackTop != '0) stackTop <= stackTop - 1'b1; // Reuse latest freed
      else usedCount <= usedCount + 1'b1;
    end else if (allocBus.free) begin
      allocBits[allocBus.queryArray] <= 1'b0;   // Drop this grant
      stackTop <= stackTop + 1'b1;
    end
  end

  // Freed array numbers, pushed on free
  always_ff @(posedge clock) begin
    if (allocBus.free && !allocBus.clear) begin
      freedStack[ArrayBits'(stackTop)] <= allocBus.queryArray;
    end
  end

endmodule

`default_nettype wire

// File: arrayStore.sv
/*
  Array store
  Holds the array words and sizes, computes the value each op returns
  and applies writes, pushes, pops and element arithmetic on commit
*/
`timescale 1ns/1ps
`default_nettype none

module arrayStore #(
  parameter int ArrayBits = arrayPkg::DefaultArrayBits,
  parameter int IndexBits = arrayPkg::DefaultIndexBits
) (
  input  wire            clock,
  input  wire            resetN,
  storeIf.store          storeBus
);
  import arrayPkg::*;

  localparam int ArrayCount  = 2 ** ArrayBits;
  localparam int ArrayLength = 2 ** IndexBits;

  dataWord_t            words [ArrayCount][ArrayLength];
  logic [IndexBits:0]   sizes [ArrayCount];
  logic [IndexBits-1:0] topIndex;               // Slot of the last word

  assign storeBus.size    = sizes[storeBus.array];
  assign storeBus.element = words[storeBus.array][storeBus.index];
  assign topIndex         = IndexBits'(storeBus.size - 1'b1);

  // ----------------------------------------------------------
  // Returned value, for every opcode
  // ----------------------------------------------------------
  always_comb begin
    case (storeBus.op)
      opWrite: storeBus.result = storeBus.data;
      opRead:  storeBus.result = storeBus.element;
      opSize:  storeBus.result = dataWord_t'(storeBus.size);
      opPop:   storeBus.result = words[storeBus.array][topIndex];
      opAdd:   storeBus.result = storeBus.element + storeBus.data; // Wraps at 16 bits
      opAnd:   storeBus.result = storeBus.element & storeBus.data;
      opOr:    storeBus.result = storeBus.element | storeBus.data;
      opXor:   storeBus.result = storeBus.element ^ storeBus.data;
      default: storeBus.result = '0;           // Alloc, free, clear, push
    endcase
  end

  // Per-array sizes
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < ArrayCount; a++) begin
        sizes[a] <= '0;
      end
    end else if (storeBus.commit) begin
      case (storeBus.op)
        opAlloc: sizes[storeBus.array] <= '0;   // Granted array starts empty
        opWrite: begin
          if ({1'b0, storeBus.index} >= storeBus.size) begin
            sizes[storeBus.array] <= {1'b0, storeBus.index} + 1'b1; // Grow to cover index
          end
        end
        opPush:  sizes[storeBus.array] <= storeBus.size + 1'b1;
        opPop:   sizes[storeBus.array] <= storeBus.size - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (storeBus.commit) begin
      case (storeBus.op)
        opWrite: words[storeBus.array][storeBus.index] <= storeBus.data;
        opPush:  words[storeBus.array][IndexBits'(storeBus.size)] <= storeBus.data;
        opAdd, opAnd, opOr, opXor: begin
          words[storeBus.array][storeBus.index] <= storeBus.result; // New value
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: arrayControl.sv
/*
  Array engine control
  Request/response handshake FSM, request registers and error checks
*/
`timescale 1ns/1ps
`default_nettype none

module arrayControl #(
  parameter int ArrayBits = arrayPkg::DefaultArrayBits,
  parameter int IndexBits = arrayPkg::DefaultIndexBits
) (
  input  wire                   clock,
  input  wire                   resetN,
  input  wire                   reqValid,
  output logic                  reqReady,
  input  arrayPkg::arrayOp_e    reqOp,
  input  wire [ArrayBits-1:0]   reqArray,
  input  wire [IndexBits-1:0]   reqIndex,
  input  arrayPkg::dataWord_t   reqData,
  output logic                  respValid,
  input  wire                   respReady,
  output arrayPkg::dataWord_t   respData,
  output arrayPkg::arrayError_e respError,
  allocIf.control               allocBus,
  storeIf.control               storeBus
);
  import arrayPkg::*;

  localparam int ArrayLength = 2 ** IndexBits;

  typedef enum logic [1:0] {stateIdle, stateExecute, stateRespond} state_e;

  state_e               state;
  arrayOp_e             opReg;
  logic [ArrayBits-1:0] arrayReg;
  logic [IndexBits-1:0] indexReg;
  dataWord_t            dataReg;
  arrayError_e          errorCode;
  logic                 execOk;                 // Execute cycle with no error

  assign reqReady = (state == stateIdle);

  // ----------------------------------------------------------
  // Error checks, first match wins
  // ----------------------------------------------------------
  always_comb begin
    errorCode = errNone;
    if (!(opReg inside {opClear, opAlloc}) && !allocBus.allocated) begin
      errorCode = errNotAllocated;
    end else if ((opReg inside {opRead, opAdd, opAnd, opOr, opXor})
                 && ({1'b0, indexReg} >= storeBus.size)) begin
      errorCode = errOutOfBounds;
    end else if (opReg == opPush && storeBus.size >= ArrayLength) begin
      errorCode = errFull;
    end else if (opReg == opPop && storeBus.size == '0) begin
      errorCode = errEmpty;
    end else if (opReg == opAlloc && allocBus.exhausted) begin
      errorCode = errOutOfMemory;
    end
  end

  assign execOk = (state == stateExecute) && (errorCode == errNone);

  assign allocBus.queryArray = arrayReg;
  assign allocBus.clear      = execOk && (opReg == opClear);
  assign allocBus.alloc      = execOk && (opReg == opAlloc);
  assign allocBus.free       = execOk && (opReg == opFree);

  assign storeBus.op     = opReg;
  assign storeBus.array  = (opReg == opAlloc) ? allocBus.newArray : arrayReg;
  assign storeBus.index  = indexReg;
  assign storeBus.data   = dataReg;
  assign storeBus.commit = execOk;

  // ----------------------------------------------------------
  // Handshake FSM
  // ----------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state     <= stateIdle;
      respValid <= 1'b0;
    end else begin
      case (state)
        stateIdle:    if (reqValid) state <= stateExecute;
        stateExecute: begin
          state     <= stateRespond;
          respValid <= 1'b1;                    // Two edges after accept
        end
        stateRespond: begin
          if (respReady) begin                  // Held until taken
            state     <= stateIdle;
            respValid <= 1'b0;
          end
        end
        default:      state <= stateIdle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == stateIdle && reqValid) begin
      opReg    <= reqOp;
      arrayReg <= reqArray;
      indexReg <= reqIndex;
      dataReg  <= reqData;
    end
    if (state == stateExecute) begin
      respError <= errorCode;
      if (errorCode != errNone) respData <= '0;
      else if (opReg == opAlloc) respData <= dataWord_t'(allocBus.newArray); // Grant
      else respData <= storeBus.result;
    end
  end

endmodule

`default_nettype wire

// File: arrayMemoryTop.sv
/*
  Array memory engine top level
  Connects control, allocator and store behind plain request and response ports
*/
`timescale 1ns/1ps
`default_nettype none

module arrayMemoryTop #(
  parameter int ArrayBits = arrayPkg::DefaultArrayBits,
  parameter int IndexBits = arrayPkg::DefaultIndexBits
) (
  input  wire                   clock,
  input  wire                   resetN,
  input  wire                   reqValid,
  output logic                  reqReady,
  input  arrayPkg::arrayOp_e    reqOp,
  input  wire [ArrayBits-1:0]   reqArray,
  input  wire [IndexBits-1:0]   reqIndex,
  input  arrayPkg::dataWord_t   reqData,
  output logic                  respValid,
  input  wire                   respReady,
  output arrayPkg::dataWord_t   respData,
  output arrayPkg::arrayError_e respError
);

  allocIf #(.ArrayBits(ArrayBits)) allocBus ();
  storeIf #(.ArrayBits(ArrayBits), .IndexBits(IndexBits)) storeBus ();

  arrayControl #(
    .ArrayBits (ArrayBits),
    .IndexBits (IndexBits)
  ) control (
    .clock     (clock),
    .resetN    (resetN),
    .reqValid  (reqValid),
    .reqReady  (reqReady),
    .reqOp     (reqOp),
    .reqArray  (reqArray),
    .reqIndex  (reqIndex),
    .reqData   (reqData),
    .respValid (respValid),
    .respReady (respReady),
    .respData  (respData),
    .respError (respError),
    .allocBus  (allocBus.control),
    .storeBus  (storeBus.control)
  );

  arrayAllocator #(.ArrayBits(ArrayBits)) allocator (
    .clock    (clock),
    .resetN   (resetN),
    .allocBus (allocBus.allocator)
  );

  arrayStore #(.ArrayBits(ArrayBits), .IndexBits(IndexBits)) store (
    .clock    (clock),
    .resetN   (resetN),
    .storeBus (storeBus.store)
  );

endmodule

`default_nettype wire

// File: arrayMemoryTop_chk.sv
/*
  Handshake assertions for the array engine control, bound into arrayControl
*/
`timescale 1ns/1ps
`default_nettype none

module arrayMemoryTop_chk (
  input wire                   clock,
  input wire                   resetN,
  input wire                   reqReady,
  input wire                   respValid,
  input wire                   respReady,
  input arrayPkg::dataWord_t   respData,
  input arrayPkg::arrayError_e respError
);

  // One request in flight at most
  readyWhileValid: assert property (@(posedge clock) disable iff (!resetN)
    respValid |-> !reqReady)
    else $error("reqReady high while a response is pending");

  responseHeld: assert property (@(posedge clock) disable iff (!resetN)
    respValid && !respReady |=> respValid && $stable(respData) && $stable(respError))
    else $error("response dropped or changed before it was taken");

  readyAfterReset: assert property (@(posedge clock) $rose(resetN) |-> reqReady)
    else $error("reqReady low in the cycle after reset release");

endmodule

`default_nettype wire

// File: arrayMemoryTop_tb.sv
/*
  Array memory engine testbench
  Directed tests checked against a rules model, with back-pressure and a watchdog
*/
`timescale 1ns/1ps
`default_nettype none

module arrayMemoryTop_tb;
  import arrayPkg::*;

  localparam int ArrayBits       = DefaultArrayBits;
  localparam int IndexBits       = DefaultIndexBits;
  localparam int ArrayCount      = 2 ** ArrayBits;
  localparam int ArrayLength     = 2 ** IndexBits;
  localparam int ClockPeriod     = 8;
  localparam int PlannedRequests = 70;          // All tests together, rounded up

  logic                 clock;
  logic                 resetN;
  logic                 reqValid;
  logic                 reqReady;
  arrayOp_e             reqOp;
  logic [ArrayBits-1:0] reqArray;
  logic [IndexBits-1:0] reqIndex;
  dataWord_t            reqData;
  logic                 respValid;
  logic                 respReady;
  dataWord_t            respData;
  arrayError_e          respError;

  integer      seed = 32'h7adc_ddb7;
  int          dataErrors = 0;
  int          codeErrors = 0;
  int          protocolErrors = 0;
  dataWord_t   lastData;                        // Response of the latest request
  arrayError_e lastError;

  // Rules model of the engine state
  logic [ArrayCount-1:0] allocModel;
  int                    freedModel [$];        // Back of queue is the latest freed
  int                    usedModel;
  int                    sizeModel [ArrayCount];
  dataWord_t             wordModel [ArrayCount][ArrayLength];

  arrayMemoryTop #(.ArrayBits(ArrayBits), .IndexBits(IndexBits)) UUT (.*);

  bind arrayControl arrayMemoryTop_chk handshakeChecks (.clock(clock), .resetN(resetN),
    .reqReady(reqReady), .respValid(respValid), .respReady(respReady),
    .respData(respData), .respError(respError));

  initial begin
    clock = 1'b0;
    forever #(ClockPeriod / 2) clock = ~clock;
  end

  initial begin
    #(ClockPeriod * PlannedRequests * 40);
    $display("Watchdog expired, the engine stopped responding at %0t ns", $time);
    $display("Test failed");
    $finish;
  end

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic checkData(input dataWord_t actual, input dataWord_t expected,
                           input string name);
    if (actual !== expected) begin
      dataErrors++;
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic checkError(input arrayError_e actual, input arrayError_e expected,
                            input string name);
    if (actual !== expected) begin
      codeErrors++;
      $display("mismatch at %0t ns: %s expected %s, got %s", $time, name,
               expected.name(), actual.name());
    end
  endtask

  // Applies the error rules in order, then the effect on the model
  task automatic predictResponse(input arrayOp_e op, input int arr, input int idx,
                                 input dataWord_t data, output dataWord_t expData,
                                 output arrayError_e expErr);
    dataWord_t oldWord;
    expData = '0;
    expErr  = errNone;
    oldWord = wordModel[arr][idx];
    if (!(op inside {opClear, opAlloc}) && !allocModel[arr]) expErr = errNotAllocated;
    else if ((op inside {opRead, opAdd, opAnd, opOr, opXor}) && idx >= sizeModel[arr])
      expErr = errOutOfBounds;
    else if (op == opPush && sizeModel[arr] >= ArrayLength) expErr = errFull;
    else if (op == opPop && sizeModel[arr] == 0) expErr = errEmpty;
    else if (op == opAlloc && freedModel.size() == 0 && usedModel == ArrayCount)
      expErr = errOutOfMemory;
    if (expErr != errNone) return;
    case (op)
      opClear: begin
        allocModel = '0;
        freedModel.delete();
        usedModel = 0;
      end
      opAlloc: begin
        if (freedModel.size() > 0) arr = freedModel.pop_back(); // Latest freed first
        else begin
          arr = usedModel;
          usedModel = usedModel + 1;
        end
        allocModel[arr] = 1'b1;
        sizeModel[arr]  = 0;
        expData = dataWord_t'(arr);
      end
      opFree: begin
        allocModel[arr] = 1'b0;
        freedModel.push_back(arr);
      end
      opWrite: begin
        wordModel[arr][idx] = data;
        if (idx >= sizeModel[arr]) sizeModel[arr] = idx + 1;
        expData = data;
      end
      opRead:  expData = oldWord;
      opSize:  expData = dataWord_t'(sizeModel[arr]);
      opPush: begin
        wordModel[arr][sizeModel[arr]] = data;
        sizeModel[arr] = sizeModel[arr] + 1;
      end
      opPop: begin
        sizeModel[arr] = sizeModel[arr] - 1;
        expData = wordModel[arr][sizeModel[arr]];
      end
      opAdd:   expData = oldWord + data;        // Truncates to 16 bits
      opAnd:   expData = oldWord & data;
      opOr:    expData = oldWord | data;
      opXor:   expData = oldWord ^ data;
      default: ;
    endcase
    if (op inside {opAdd, opAnd, opOr, opXor}) wordModel[arr][idx] = expData;
  endtask

  // ----------------------------------------------------------
  // Request and response handshake
  // ----------------------------------------------------------
  task automatic sendRequest(input arrayOp_e op, input int arr, input int idx,
                             input dataWord_t data, input int hold);
    logic wasReady;
    wasReady = 1'b0;
    reqOp    = op;
    reqArray = ArrayBits'(arr);
    reqIndex = IndexBits'(idx);
    reqData  = data;
    reqValid = 1'b1;
    while (!wasReady) begin
      wasReady = reqReady;                      // Accepted on the coming edge
      @(posedge clock);
      #1;
    end
    reqValid = 1'b0;
    @(posedge clock);
    #1;
    if (!respValid) begin
      protocolErrors++;
      $display("No response two edges after the request was accepted at %0t ns", $time);
      while (!respValid) begin
        @(posedge clock);
        #1;
      end
    end
    lastData  = respData;
    lastError = respError;
    reqValid  = 1'b1;                           // Must be refused while busy
    repeat (hold) begin
      @(posedge clock);
      #1;
      if (!respValid || reqReady || respData !== lastData || respError !== lastError) begin
        protocolErrors++;
        $display("Response not held or request ready under back-pressure at %0t ns", $time);
      end
    end
    reqValid  = 1'b0;
    respReady = 1'b1;
    @(posedge clock);
    #1;
    respReady = 1'b0;
    if (respValid) begin
      protocolErrors++;
      $display("Response still valid after it was taken at %0t ns", $time);
    end
  endtask

  task automatic requestAndCheck(input arrayOp_e op, input int arr, input int idx,
                                 input dataWord_t data, input int hold);
    dataWord_t   expData;
    arrayError_e expErr;
    sendRequest(op, arr, idx, data, hold);
    predictResponse(op, arr, idx, data, expData, expErr);
    checkError(lastError, expErr, "respError");
    if (!$isunknown(expData)) checkData(lastData, expData, "respData"); // Unwritten words
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic allocateAll();
    for (int a = 0; a < ArrayCount; a++) begin
      requestAndCheck(opAlloc, 0, 0, '0, 0);
      checkData(lastData, dataWord_t'(a), "respData");
    end
    requestAndCheck(opAlloc, 0, 0, '0, 0);
    checkError(lastError, errOutOfMemory, "respError");
  endtask

  task automatic freeAndReuse();
    requestAndCheck(opFree, 1, 0, '0, 0);
    requestAndCheck(opFree, 2, 0, '0, 0);
    requestAndCheck(opRead, 1, 0, '0, 0);
    requestAndCheck(opFree, 1, 0, '0, 0);     // Double free
    checkError(lastError, errNotAllocated, "respError");
    requestAndCheck(opAlloc, 0, 0, '0, 0);
    checkData(lastData, 16'd2, "respData");
    requestAndCheck(opAlloc, 0, 0, '0, 0);
    checkData(lastData, 16'd1, "respData");
    requestAndCheck(opClear, 0, 0, '0, 0);
    for (int a = 0; a < ArrayCount; a++) requestAndCheck(opRead, a, 0, '0, 0);
    requestAndCheck(opAlloc, 0, 0, '0, 0);    // Array 0 for the next test
  endtask

  task automatic writeReadSize();
    requestAndCheck(opWrite, 0, 2, dataWord_t'($random(seed)), 0);
    requestAndCheck(opSize, 0, 0, '0, 0);
    checkData(lastData, 16'd3, "respData");
    for (int i = 0; i < 3; i++) requestAndCheck(opRead, 0, i, '0, 0);
    requestAndCheck(opRead, 0, 3, '0, 0);
    checkError(lastError, errOutOfBounds, "respError");
  endtask

  task automatic pushPop();
    dataWord_t pushed [$];
    requestAndCheck(opAlloc, 0, 0, '0, 0);
    for (int i = 0; i < ArrayLength; i++) begin
      pushed.push_back(dataWord_t'($random(seed)));
      requestAndCheck(opPush, 1, 0, pushed[i], 0);
    end
    requestAndCheck(opPush, 1, 0, 16'hdead, 0);
    checkError(lastError, errFull, "respError");
    for (int i = 0; i < ArrayLength; i++) begin
      requestAndCheck(opPop, 1, 0, '0, 0);
      checkData(lastData, pushed.pop_back(), "respData"); // Reverse order
    end
    requestAndCheck(opPop, 1, 0, '0, 0);
    checkError(lastError, errEmpty, "respError");
  endtask

  task automatic elementOps();
    arrayOp_e  ops [4] = '{opAdd, opAnd, opOr, opXor};
    dataWord_t newValue;
    int        idx;
    requestAndCheck(opAlloc, 0, 0, '0, 0);
    for (int i = 0; i < ArrayLength; i++) begin
      requestAndCheck(opWrite, 2, i, dataWord_t'($random(seed)), 0);
    end
    foreach (ops[k]) begin
      idx = $unsigned($random(seed)) % ArrayLength;
      requestAndCheck(ops[k], 2, idx, dataWord_t'($random(seed)), 0);
      newValue = lastData;
      requestAndCheck(opRead, 2, idx, '0, 0);
      checkData(lastData, newValue, "respData");
    end
  endtask

  task automatic backPressure();
    arrayOp_e mixOps [9] = '{opWrite, opRead, opSize, opPush, opPop,
                             opAdd, opAnd, opOr, opXor};
    for (int n = 0; n < 20; n++) begin
      requestAndCheck(mixOps[$unsigned($random(seed)) % 9], $unsigned($random(seed)) % ArrayCount,
                      $unsigned($random(seed)) % ArrayLength, dataWord_t'($random(seed)),
                      2 + $unsigned($random(seed)) % 4);
    end
  endtask

  initial begin
    resetN     = 1'b0;
    reqValid   = 1'b0;
    reqOp      = opClear;
    reqArray   = '0;
    reqIndex   = '0;
    reqData    = '0;
    respReady  = 1'b0;
    allocModel = '0;
    usedModel  = 0;
    foreach (sizeModel[a]) sizeModel[a] = 0;
    repeat (5) @(posedge clock);
    #1;
    resetN = 1'b1;
    if (!reqReady || respValid) begin
      protocolErrors++;
      $display("Engine not idle after reset at %0t ns", $time);
    end
    allocateAll();
    freeAndReuse();
    writeReadSize();
    pushPop();
    elementOps();
    backPressure();
    $display("Errors: data %0d, error code %0d, protocol %0d",
             dataErrors, codeErrors, protocolErrors);
    if (dataErrors + codeErrors + protocolErrors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: arrayMemoryTop.f
arrayPkg.sv
arrayIf.sv
arrayAllocator.sv
arrayStore.sv
arrayControl.sv
arrayMemoryTop.sv
arrayMemoryTop_chk.sv
arrayMemoryTop_tb.sv

// File: Makefile
# Verilator build and run for the array memory engine testbench

VERILATOR ?= verilator
TOP       ?= arrayMemoryTop_tb
FILELIST  ?= arrayMemoryTop.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
